//--- arb_pkg.sv
package arb_pkg;

	// message opcode, upper two bits of the header byte
	typedef enum logic [1:0] {
		op_short = 2'b00, // one data byte
		op_long  = 2'b01, // four data bytes
		op_rsv2  = 2'b10, // reserved, sent like op_short
		op_rsv3  = 2'b11
	} msg_op_e;

	typedef enum logic {
		st_idle,
		st_send
	} fsm_state_e;

	// one message as delivered by a port
	typedef struct packed {
		msg_op_e     op;
		logic [7:0]  tag;  // traceability only, never on the link
		logic [31:0] data;
	} msg_t;

	typedef struct packed {
		logic       valid;
		logic       last;
		logic [7:0] data;
	} link_t;

	// source index field of the header, limits the port count to 64
	localparam int HDR_SRC_BITS = 6;
	localparam int BEAT_W       = 3;

	// beats per burst, header included
	function automatic logic [BEAT_W-1:0] burst_beats(msg_op_e op);
		if (op == op_long)
			return 3'd5;
		return 3'd2;
	endfunction

endpackage

//--- rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int NUM_PORTS = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] request,
	input  logic                 accept,
	output logic [NUM_PORTS-1:0] grant,
	output logic                 any_grant
);

	logic [NUM_PORTS-1:0] pr;            // rotation mask, ones from the next favoured port up
	logic [NUM_PORTS-1:0] masked_request;
	logic [NUM_PORTS-1:0] thermo_req;
	logic [NUM_PORTS-1:0] thermo_masked;
	logic [NUM_PORTS-1:0] mux_out;
	logic [NUM_PORTS-1:0] edge_mask;

	assign masked_request = request & pr;

	// prefix or, bit i set once any request at or below i is set
	always_comb begin
		thermo_req[0] = request[0];
		thermo_masked[0] = masked_request[0];
		for (int i = 1; i < NUM_PORTS; i++) begin
			thermo_req[i] = thermo_req[i-1] | request[i];
			thermo_masked[i] = thermo_masked[i-1] | masked_request[i];
		end
	end

	// fall back to the plain code once nothing above the pointer requests
	assign mux_out = thermo_masked[NUM_PORTS-1] ? thermo_masked : thermo_req;
	assign edge_mask = {mux_out[NUM_PORTS-2:0], 1'b0};
	assign grant = mux_out ^ edge_mask;
	assign any_grant = thermo_req[NUM_PORTS-1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pr <= '1; // port 0 first
		else if (accept)
			pr <= edge_mask; // winner drops to lowest priority
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

	a_grant_requested: assert property (@(posedge clk) disable iff (reset)
		(grant & ~request) == '0);

	a_any_grant: assert property (@(posedge clk) disable iff (reset)
		any_grant == (|request));

endmodule

//--- request_slots.sv
`timescale 1ns/1ps

module request_slots #(
	parameter int NUM_PORTS = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] port_valid,
	input  arb_pkg::msg_t        port_msg [NUM_PORTS],
	input  logic [NUM_PORTS-1:0] grant,
	input  logic                 accept,
	output logic [NUM_PORTS-1:0] pending,
	output arb_pkg::msg_t        slot_msg [NUM_PORTS],
	output logic [NUM_PORTS-1:0] port_drop
);

	import arb_pkg::*;

	logic [NUM_PORTS-1:0] take;  // slot leaves for the link this edge
	logic [NUM_PORTS-1:0] store; // strobe lands in its slot

	assign take = grant & {NUM_PORTS{accept}};
	assign store = port_valid & (~pending | take);

	// pending flags and drop strobes
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending <= '0;
			port_drop <= '0;
		end else begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				port_drop[i] <= port_valid[i] & pending[i] & ~take[i];
				if (store[i])
					pending[i] <= 1'b1; // new message wins over the clear
				else if (take[i])
					pending[i] <= 1'b0;
			end
		end
	end

	// message payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (store[i])
				slot_msg[i] <= port_msg[i];
		end
	end

endmodule

//--- link_fsm.sv
`timescale 1ns/1ps

module link_fsm (
	input  logic clk,
	input  logic reset,
	input  logic any_grant,
	input  logic last_beat,
	output logic accept,
	output logic link_valid
);

	import arb_pkg::*;

	fsm_state_e state;

	// take a grant only between bursts
	assign accept = (state == st_idle) && any_grant;
	assign link_valid = (state == st_send);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (any_grant)
						state <= st_send;
				end
				st_send: begin
					if (last_beat)
						state <= st_idle; // one idle cycle before the next accept
				end
				default: state <= st_idle;
			endcase
		end
	end

	// accept is taken in idle and the header follows in the very next cycle
	a_accept_in_idle: assert property (@(posedge clk) disable iff (reset)
		accept |-> (state == st_idle) ##1 link_valid);

	// the counter marks a last beat only inside a burst
	a_last_in_burst: assert property (@(posedge clk) disable iff (reset)
		last_beat |-> link_valid);

endmodule

//--- beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic [arb_pkg::BEAT_W-1:0] beats,
	output logic [arb_pkg::BEAT_W-1:0] beat,
	output logic                       last_beat
);

	import arb_pkg::*;

	logic running;

	// beats is valid from the first beat on, held by the serializer
	assign last_beat = running && (beat == beats - BEAT_W'(1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			beat <= '0;
		end else if (start) begin
			running <= 1'b1;
			beat <= '0; // header beat
		end else if (running) begin
			if (last_beat) begin
				running <= 1'b0;
				beat <= '0;
			end else begin
				beat <= beat + BEAT_W'(1);
			end
		end
	end

	a_no_restart: assert property (@(posedge clk) disable iff (reset)
		start |-> !running);

endmodule

//--- msg_serializer.sv
`timescale 1ns/1ps

module msg_serializer #(
	parameter int NUM_PORTS = 4
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       accept,
	input  logic [NUM_PORTS-1:0]       grant,
	input  arb_pkg::msg_t              slot_msg [NUM_PORTS],
	input  logic [arb_pkg::BEAT_W-1:0] beat,
	output logic [arb_pkg::BEAT_W-1:0] beats,
	output logic [7:0]                 data
);

	import arb_pkg::*;

	msg_t                    sel_msg;
	logic [HDR_SRC_BITS-1:0] sel_src;
	msg_op_e                 cap_op;
	logic [HDR_SRC_BITS-1:0] cap_src;
	logic [31:0]             cap_data;

	// one-hot mux and index encode in one pass
	always_comb begin
		sel_msg = '0;
		sel_src = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (grant[i]) begin
				sel_msg = msg_t'(sel_msg | slot_msg[i]);
				sel_src = sel_src | HDR_SRC_BITS'(i);
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cap_op <= op_short;
			cap_src <= '0;
		end else if (accept) begin
			cap_op <= sel_msg.op;
			cap_src <= sel_src;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cap_data <= sel_msg.data;
	end

	assign beats = burst_beats(cap_op); // stable for the whole burst

	// header first, then data lsb first
	always_comb begin
		case (beat)
			3'd1: data = cap_data[7:0];
			3'd2: data = cap_data[15:8];
			3'd3: data = cap_data[23:16];
			3'd4: data = cap_data[31:24];
			default: data = {cap_op, cap_src};
		endcase
	end

endmodule

//--- shared_link_top.sv
`timescale 1ns/1ps

module shared_link_top #(
	parameter int NUM_PORTS = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] port_valid,
	input  arb_pkg::msg_t        port_msg [NUM_PORTS],
	output arb_pkg::link_t       link,
	output logic [NUM_PORTS-1:0] port_drop
);

	import arb_pkg::*;

	logic [NUM_PORTS-1:0] pending;
	msg_t                 slot_msg [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant;
	logic                 any_grant;
	logic                 accept;
	logic                 link_valid;
	logic [BEAT_W-1:0]    beat;
	logic [BEAT_W-1:0]    beats;
	logic                 last_beat;
	logic [7:0]           link_data;

	request_slots #(.NUM_PORTS(NUM_PORTS)) i_slots (
		.clk        (clk),
		.reset      (reset),
		.port_valid (port_valid),
		.port_msg   (port_msg),
		.grant      (grant),
		.accept     (accept),
		.pending    (pending),
		.slot_msg   (slot_msg),
		.port_drop  (port_drop)
	);

	rr_arbiter #(.NUM_PORTS(NUM_PORTS)) i_arb (
		.clk       (clk),
		.reset     (reset),
		.request   (pending),
		.accept    (accept), // pointer moves only on a taken grant
		.grant     (grant),
		.any_grant (any_grant)
	);

	link_fsm i_fsm (
		.clk        (clk),
		.reset      (reset),
		.any_grant  (any_grant),
		.last_beat  (last_beat),
		.accept     (accept),
		.link_valid (link_valid)
	);

	beat_counter i_beats (
		.clk       (clk),
		.reset     (reset),
		.start     (accept),
		.beats     (beats),
		.beat      (beat),
		.last_beat (last_beat)
	);

	msg_serializer #(.NUM_PORTS(NUM_PORTS)) i_ser (
		.clk      (clk),
		.reset    (reset),
		.accept   (accept),
		.grant    (grant),
		.slot_msg (slot_msg),
		.beat     (beat),
		.beats    (beats),
		.data     (link_data)
	);

	assign link = '{valid: link_valid, last: link_valid & last_beat, data: link_data};

endmodule

//--- tb_shared_link.sv
`timescale 1ns/1ps

module tb_shared_link;

	import arb_pkg::*;

	localparam int NUM_PORTS       = 4;
	localparam int RAND_CYCLES     = 300;
	localparam int MAX_MSGS        = 15 + RAND_CYCLES * NUM_PORTS;
	localparam int WATCHDOG_CYCLES = MAX_MSGS * 7 + 500; // 7 cycles per message at most

	logic                 clk;
	logic                 reset;
	logic [NUM_PORTS-1:0] port_valid;
	msg_t                 port_msg [NUM_PORTS];
	link_t                link;
	logic [NUM_PORTS-1:0] port_drop;

	logic [NUM_PORTS-1:0] m_pending; // reference slot flags
	msg_t                 m_msg [NUM_PORTS];
	int                   m_ptr;     // where the next grant search starts
	int                   m_busy;    // beats left in the running burst
	logic [NUM_PORTS-1:0] m_drop;    // drops due on the next edge
	logic [8:0]           exp_q [$]; // {last, data}
	int                   served_src [$];
	bit                   in_burst;
	int                   drop_seen;
	int                   errors;
	int                   checks;
	int                   tests;
	integer               seed;
	msg_t                 next_msg [NUM_PORTS];

	shared_link_top #(.NUM_PORTS(NUM_PORTS)) i_dut (
		.clk        (clk),
		.reset      (reset),
		.port_valid (port_valid),
		.port_msg   (port_msg),
		.link       (link),
		.port_drop  (port_drop)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int beats_for(msg_op_e code);
		return (code == op_long) ? 5 : 2;
	endfunction

	// beat idx of a message from port src, last flag on top
	function automatic logic [8:0] ref_beat(msg_t m, int src, int idx);
		logic [7:0] b;
		logic       last;
		if (idx == 0)
			b = {m.op, 6'(src)};
		else
			b = m.data[8*(idx-1) +: 8]; // lsb first
		last = (idx == beats_for(m.op) - 1);
		return {last, b};
	endfunction

	function automatic msg_t make_msg(msg_op_e code, logic [31:0] payload, logic [7:0] id);
		return '{op: code, tag: id, data: payload};
	endfunction

	// transaction level slots and arbiter, one step per edge
	always @(posedge clk) begin : ref_model
		int win;
		if (!reset) begin
			checks++;
			assert (port_drop == m_drop) else begin
				$display("FAIL %0t: port_drop %b, expected %b", $time, port_drop, m_drop);
				errors++;
			end
		end
		for (int p = 0; p < NUM_PORTS; p++)
			if (port_drop[p] === 1'b1)
				drop_seen++;
		if (reset) begin
			m_pending = '0;
			m_ptr = 0;
			m_busy = 0;
			m_drop = '0;
			exp_q.delete();
		end else begin
			win = -1;
			if (m_busy == 0) begin
				for (int k = 0; k < NUM_PORTS; k++)
					if (win < 0 && m_pending[(m_ptr + k) % NUM_PORTS])
						win = (m_ptr + k) % NUM_PORTS;
			end else begin
				m_busy--;
			end
			if (win >= 0) begin
				for (int i = 0; i < beats_for(m_msg[win].op); i++)
					exp_q.push_back(ref_beat(m_msg[win], win, i));
				m_pending[win] = 1'b0;
				m_ptr = (win + 1) % NUM_PORTS;
				m_busy = beats_for(m_msg[win].op);
			end
			for (int p = 0; p < NUM_PORTS; p++) begin
				m_drop[p] = port_valid[p] && m_pending[p];
				if (port_valid[p] && !m_pending[p]) begin
					m_pending[p] = 1'b1;
					m_msg[p] = port_msg[p];
				end
			end
		end
	end

	always @(posedge clk) begin : link_check
		logic [8:0] want;
		if (reset) begin
			in_burst = 1'b0;
		end else if (link.valid) begin
			checks++;
			assert (exp_q.size() > 0) else begin
				$display("ERROR %0t: link sent a beat while no message was expected", $time);
				errors++;
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				assert ({link.last, link.data} == want) else begin
					$display("FAIL %0t: link last %b data %h, expected last %b data %h",
						$time, link.last, link.data, want[8], want[7:0]);
					errors++;
				end
			end
			if (!in_burst)
				served_src.push_back(int'(link.data[5:0])); // header source field
			in_burst = !link.last;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: the run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	task automatic hold_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic drive(input logic [NUM_PORTS-1:0] mask);
		@(posedge clk);
		port_valid <= mask;
		for (int p = 0; p < NUM_PORTS; p++)
			if (mask[p])
				port_msg[p] <= next_msg[p];
	endtask

	// wait until every slot is served and the link is quiet
	task automatic wait_idle(input int max_cycles);
		int n;
		n = 0;
		#1; // past the edge that samples the last strobe
		while ((m_pending != '0 || m_busy != 0 || exp_q.size() != 0 || link.valid)
				&& n < max_cycles) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= max_cycles) begin
			$display("ERROR %0t: the link did not go idle within %0d cycles", $time, max_cycles);
			errors++;
		end
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic expect_true(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("FAIL %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic expect_order(input int want[$], input string what);
		expect_true(served_src == want, $sformatf("%s order %p, expected %p",
			what, served_src, want));
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err_before);
	endtask

	initial begin : stimulus
		int                   err0;
		int                   drops0;
		int                   sent;
		int                   want [$];
		logic [NUM_PORTS-1:0] mask;
		seed = 32'h5ce9ddc5;
		errors = 0;
		checks = 0;
		tests = 0;
		drop_seen = 0;
		reset = 1'b1;
		port_valid = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_msg[p] = '0;
			next_msg[p] = '0;
		end
		hold_reset();

		err0 = errors;
		repeat (4) begin
			@(posedge clk);
			#1;
			expect_true(!link.valid, "link valid before any strobe");
		end
		next_msg[1] = make_msg(op_short, 32'h5a3c_e1d7, 8'h01);
		drive(4'b0010);
		drive('0);
		wait_idle(50);
		next_msg[2] = make_msg(op_long, 32'h8421_f00d, 8'h02);
		drive(4'b0100);
		drive('0);
		wait_idle(50);
		want = '{1, 2};
		expect_order(want, "single messages");
		end_test("single short and long", err0);

		err0 = errors;
		hold_reset();
		served_src.delete();
		for (int p = 0; p < NUM_PORTS; p++)
			next_msg[p] = make_msg(p[0] ? op_long : op_short, 32'h1000_0001 * (p + 1), 8'(p));
		drive(4'b1111);
		drive('0);
		wait_idle(100);
		drive(4'b0101);
		drive('0);
		wait_idle(100);
		drive(4'b1011);
		drive('0);
		wait_idle(100);
		want = '{0, 1, 2, 3, 0, 2, 3, 0, 1}; // pointer carries over between rounds
		expect_order(want, "round robin");
		end_test("round robin order", err0);

		err0 = errors;
		drops0 = drop_seen;
		served_src.delete();
		next_msg[0] = make_msg(op_long, 32'hdead_beef, 8'h10);
		drive(4'b0001);
		next_msg[2] = make_msg(op_long, 32'h0bad_cafe, 8'h12);
		drive(4'b0100);
		next_msg[2] = make_msg(op_short, 32'h0000_0066, 8'h13); // lands on a full slot
		drive(4'b0100);
		drive('0);
		wait_idle(50);
		expect_true(drop_seen - drops0 == 1, "expected exactly one drop on port 2");
		want = '{0, 2};
		expect_order(want, "drop test");
		end_test("drop on full slot", err0);

		err0 = errors;
		drops0 = drop_seen;
		served_src.delete();
		next_msg[1] = make_msg(op_short, 32'h0000_00a1, 8'h20);
		drive(4'b0010);
		next_msg[1] = make_msg(op_long, 32'h7654_3210, 8'h21); // same edge as the accept
		drive(4'b0010);
		drive('0);
		wait_idle(50);
		expect_true(drop_seen == drops0, "strobe on the accept edge was dropped");
		want = '{1, 1};
		expect_order(want, "accept edge");
		end_test("strobe on accept edge", err0);

		err0 = errors;
		drops0 = drop_seen;
		sent = 0;
		repeat (RAND_CYCLES) begin
			mask = '0;
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (($random(seed) & 7) == 0) begin
					mask[p] = 1'b1;
					next_msg[p] = make_msg(($random(seed) & 1) ? op_long : op_short,
						$random(seed), 8'(sent));
					sent++;
				end
			end
			drive(mask);
		end
		drive('0);
		wait_idle(100);
		expect_true(drop_seen > drops0, "random traffic produced no drops");
		$display("random traffic: %0d strobes, %0d drops", sent, drop_seen - drops0);
		end_test("random traffic", err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
arb_pkg.sv
rr_arbiter.sv
request_slots.sv
link_fsm.sv
beat_counter.sv
msg_serializer.sv
shared_link_top.sv
tb_shared_link.sv

//--- Bender.yml
package:
  name: shared_link

sources:
  - arb_pkg.sv
  - rr_arbiter.sv
  - request_slots.sv
  - link_fsm.sv
  - beat_counter.sv
  - msg_serializer.sv
  - shared_link_top.sv
  - target: simulation
    files:
      - tb_shared_link.sv
